//--- common/eci_pkg.sv
package eci_pkg;

   // Basic ECI widths
   localparam int ECI_WORD_WIDTH = 64;
   localparam int ECI_ADDR_WIDTH = 40;
   localparam int ECI_ID_WIDTH = 6;

   // One cache line is 128 bytes, one strobe bit per byte
   localparam int ECI_CL_WIDTH = 1024;
   localparam int ECI_STRB_WIDTH = ECI_CL_WIDTH / 8;
   localparam int ECI_CL_ADDR_LSB = 7;
   localparam int ECI_CL_INDEX_WIDTH = ECI_ADDR_WIDTH - ECI_CL_ADDR_LSB;

   // Line split into four sub-cache-lines of four words each
   localparam int ECI_SCL_COUNT = 4;
   localparam int ECI_SCL_WORDS = 4;
   localparam int ECI_SCL_BYTES = ECI_STRB_WIDTH / ECI_SCL_COUNT;

   // Header word plus full line
   localparam int ECI_PKT_WORDS = 17;
   localparam int ECI_PKT_SIZE_WIDTH = 5;

   // Opcode for a write request to memory
   localparam logic [4:0] ECI_CMD_MREQ_RSTT = 5'b01101;

   // RSTT header layout, MSB first
   typedef struct packed {
      logic [4:0]                opcode;
      logic [ECI_ID_WIDTH-1:0]   rreq_id;
      logic [ECI_SCL_COUNT-1:0]  dmask;
      // Non-secure access
      logic                      ns;
      logic [7:0]                reserved;
      // Byte address, bits below the cache-line LSB are zero
      logic [ECI_ADDR_WIDTH-1:0] address;
   } eci_rstt_t;

   // Header built by fields, sent as a raw word
   typedef union packed {
      logic [ECI_WORD_WIDTH-1:0] eci_word;
      eci_rstt_t                 rstt;
   } eci_word_t;

   // Cache-line index aliasing
   // Low 5 index bits get XORed with index bits 9:5
   // Spreads strided lines over the home banks
   function automatic logic [ECI_CL_INDEX_WIDTH-1:0] eci_alias_cl(
      input logic [ECI_CL_INDEX_WIDTH-1:0] cl_index
   );
      logic [ECI_CL_INDEX_WIDTH-1:0] aliased;
      aliased = cl_index;
      aliased[4:0] = cl_index[4:0] ^ cl_index[9:5];
      return aliased;
   endfunction

endpackage

//--- design/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
   parameter int WIDTH = 8,
   parameter int DEPTH = 4
) (
   input  logic             aclk,
   input  logic             aresetn,
   input  logic [WIDTH-1:0] wr_data,
   input  logic             wr_valid,
   output logic             wr_ready,
   output logic [WIDTH-1:0] rd_data,
   output logic             rd_valid,
   input  logic             rd_pop
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // Storage array
   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_write;
   logic             do_read;

   // Ready drops only when full
   // A pop in the same cycle does not free a slot early
   assign wr_ready = (count != CNT_W'(DEPTH));
   assign rd_valid = (count != '0);
   assign rd_data  = mem[rd_ptr];

   assign do_write = wr_valid && wr_ready;
   assign do_read  = rd_pop && rd_valid;

   always_ff @(posedge aclk) begin
      if (do_write) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   // Pointers wrap at DEPTH for any depth
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_write && !do_read) begin
            count <= count + 1'b1;
         end else if (do_read && !do_write) begin
            count <= count - 1'b1;
         end
      end
   end

   // Reader must only pop a valid head
   assert property (@(posedge aclk) disable iff (!aresetn) rd_pop |-> rd_valid);
   // Pointers meet only when the FIFO is empty or full
   assert property (@(posedge aclk) disable iff (!aresetn)
      (wr_ptr == rd_ptr) == ((count == '0) || (count == CNT_W'(DEPTH))));

endmodule

//--- wr_req/wr_req_ctrl.sv
`timescale 1ns/1ns

module wr_req_ctrl #(
   parameter int VC_CREDITS = 4
) (
   input  logic aclk,
   input  logic aresetn,
   input  logic aw_head_valid,
   input  logic w_head_valid,
   input  logic w_head_last,
   input  logic vc_credit_return,
   output logic aw_pop,
   output logic w_pop,
   output logic fire
);

   localparam int CRD_W = $clog2(VC_CREDITS + 1);

   // Credits held toward the VC
   logic [CRD_W-1:0] credits;
   logic             has_credit;

   assign has_credit = (credits != '0);

   // Pair heads in arrival order
   // One pair per cycle while a credit is held
   assign fire   = aw_head_valid && w_head_valid && has_credit;
   assign aw_pop = fire;
   assign w_pop  = fire;

   // Counter update
   // fire takes one, a return gives one back
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         credits <= CRD_W'(VC_CREDITS);
      end else begin
         case ({fire, vc_credit_return})
            2'b10: credits <= credits - 1'b1;
            2'b01: credits <= credits + 1'b1;
            // Both or neither, count unchanged
            default: credits <= credits;
         endcase
      end
   end

   // Count stays within the VC buffer budget
   assert property (@(posedge aclk) disable iff (!aresetn)
      credits <= CRD_W'(VC_CREDITS));

   // VC side never returns more than it was given
   assert property (@(posedge aclk) disable iff (!aresetn)
      vc_credit_return |-> (credits != CRD_W'(VC_CREDITS)));

   // Single-beat writes only, every W beat at fire is last
   assert property (@(posedge aclk) disable iff (!aresetn)
      fire |-> w_head_last);

endmodule

//--- wr_req/rstt_hdr_gen.sv
`timescale 1ns/1ns

module rstt_hdr_gen import eci_pkg::*; (
   input  logic [ECI_ADDR_WIDTH-1:0]     hdr_addr,
   input  logic [ECI_ID_WIDTH-1:0]       hdr_id,
   input  logic [ECI_STRB_WIDTH-1:0]     hdr_strb,
   output eci_word_t                     hdr_word,
   output logic [ECI_PKT_SIZE_WIDTH-1:0] pkt_size
);

   // One bit per sub-cache-line with any byte enabled
   logic [ECI_SCL_COUNT-1:0]      dmask;
   logic [ECI_CL_INDEX_WIDTH-1:0] cl_index;
   // Sub-cache-lines sent, up to and including the highest active one
   logic [2:0]                    scl_used;

   always_comb begin
      for (int k = 0; k < ECI_SCL_COUNT; k++) begin
         dmask[k] = |hdr_strb[k*ECI_SCL_BYTES +: ECI_SCL_BYTES];
      end
   end

   // Aliased line index, offset bits dropped
   assign cl_index = eci_alias_cl(hdr_addr[ECI_ADDR_WIDTH-1:ECI_CL_ADDR_LSB]);

   // Header by fields
   always_comb begin
      hdr_word              = '0;
      hdr_word.rstt.opcode  = ECI_CMD_MREQ_RSTT;
      hdr_word.rstt.rreq_id = hdr_id;
      hdr_word.rstt.dmask   = dmask;
      hdr_word.rstt.ns      = 1'b1;
      hdr_word.rstt.address = {cl_index, {ECI_CL_ADDR_LSB{1'b0}}};
   end

   // Highest set mask bit wins
   // empty strobe still sends one sub-cache-line
   always_comb begin
      scl_used = 3'd1;
      for (int k = 0; k < ECI_SCL_COUNT; k++) begin
         if (dmask[k]) begin
            scl_used = 3'(k + 1);
         end
      end
   end

   // Header word plus four words per sub-cache-line
   assign pkt_size = ECI_PKT_SIZE_WIDTH'(1 + ECI_SCL_WORDS * scl_used);

endmodule

//--- wr_req/vc_pkt_reg.sv
`timescale 1ns/1ns

module vc_pkt_reg import eci_pkg::*; (
   input  logic                                       aclk,
   input  logic                                       aresetn,
   input  logic                                       fire,
   input  eci_word_t                                  hdr_word,
   input  logic [ECI_PKT_SIZE_WIDTH-1:0]              pkt_size,
   input  logic [ECI_CL_WIDTH-1:0]                    line_data,
   output logic [ECI_PKT_WORDS-1:0][ECI_WORD_WIDTH-1:0] vc_pkt_data,
   output logic [ECI_PKT_SIZE_WIDTH-1:0]              vc_pkt_size,
   output logic                                       vc_pkt_valid
);

   // Valid is a one-cycle strobe per fire
   always_ff @(posedge aclk) begin
      if (!aresetn) begin
         vc_pkt_valid <= 1'b0;
      end else begin
         vc_pkt_valid <= fire;
      end
   end

   // Payload holds between packets
   // Word 0 holds the header
   // Words 1..16 hold the line with the low word first
   always_ff @(posedge aclk) begin
      if (fire) begin
         vc_pkt_data[0]                 <= hdr_word.eci_word;
         vc_pkt_data[ECI_PKT_WORDS-1:1] <= line_data;
         vc_pkt_size                    <= pkt_size;
      end
   end

   // Sent size is always a whole number of sub-cache-lines
   assert property (@(posedge aclk) disable iff (!aresetn)
      vc_pkt_valid |-> (vc_pkt_size inside {5'd5, 5'd9, 5'd13, 5'd17}));

endmodule

//--- design/eci_wr_req_top.sv
`timescale 1ns/1ns

module eci_wr_req_top import eci_pkg::*; #(
   parameter int FIFO_DEPTH = 4,
   parameter int VC_CREDITS = 4
) (
   input  logic                                       aclk,
   input  logic                                       aresetn,

   // AXI write address
   input  logic [ECI_ID_WIDTH-1:0]                    s_axi_awid,
   input  logic [ECI_ADDR_WIDTH-1:0]                  s_axi_awaddr,
   input  logic                                       s_axi_awvalid,
   output logic                                       s_axi_awready,

   // AXI write data, single beat
   input  logic [ECI_CL_WIDTH-1:0]                    s_axi_wdata,
   input  logic [ECI_STRB_WIDTH-1:0]                  s_axi_wstrb,
   input  logic                                       s_axi_wlast,
   input  logic                                       s_axi_wvalid,
   output logic                                       s_axi_wready,

   // VC packet out, credit flow control
   output logic [ECI_PKT_WORDS-1:0][ECI_WORD_WIDTH-1:0] vc_pkt_data,
   output logic [ECI_PKT_SIZE_WIDTH-1:0]              vc_pkt_size,
   output logic                                       vc_pkt_valid,
   input  logic                                       vc_credit_return
);

   localparam int AW_WIDTH = ECI_ID_WIDTH + ECI_ADDR_WIDTH;
   localparam int W_WIDTH  = ECI_CL_WIDTH + ECI_STRB_WIDTH + 1;

   // AW queue head
   logic [AW_WIDTH-1:0]           aw_head;
   logic [ECI_ID_WIDTH-1:0]       aw_head_id;
   logic [ECI_ADDR_WIDTH-1:0]     aw_head_addr;
   logic                          aw_head_valid;
   logic                          aw_pop;

   // W queue head
   logic [W_WIDTH-1:0]            w_head;
   logic [ECI_CL_WIDTH-1:0]       w_head_data;
   logic [ECI_STRB_WIDTH-1:0]     w_head_strb;
   logic                          w_head_last;
   logic                          w_head_valid;
   logic                          w_pop;

   // Pairing and header
   logic                          fire;
   eci_word_t                     hdr_word;
   logic [ECI_PKT_SIZE_WIDTH-1:0] pkt_size;

   assign {aw_head_id, aw_head_addr}            = aw_head;
   assign {w_head_data, w_head_strb, w_head_last} = w_head;

   sync_fifo #(.WIDTH(AW_WIDTH), .DEPTH(FIFO_DEPTH)) u_aw_fifo (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .wr_data  ({s_axi_awid, s_axi_awaddr}),
      .wr_valid (s_axi_awvalid),
      .wr_ready (s_axi_awready),
      .rd_data  (aw_head),
      .rd_valid (aw_head_valid),
      .rd_pop   (aw_pop)
   );

   sync_fifo #(.WIDTH(W_WIDTH), .DEPTH(FIFO_DEPTH)) u_w_fifo (
      .aclk     (aclk),
      .aresetn  (aresetn),
      .wr_data  ({s_axi_wdata, s_axi_wstrb, s_axi_wlast}),
      .wr_valid (s_axi_wvalid),
      .wr_ready (s_axi_wready),
      .rd_data  (w_head),
      .rd_valid (w_head_valid),
      .rd_pop   (w_pop)
   );

   wr_req_ctrl #(.VC_CREDITS(VC_CREDITS)) u_ctrl (
      .aclk             (aclk),
      .aresetn          (aresetn),
      .aw_head_valid    (aw_head_valid),
      .w_head_valid     (w_head_valid),
      .w_head_last      (w_head_last),
      .vc_credit_return (vc_credit_return),
      .aw_pop           (aw_pop),
      .w_pop            (w_pop),
      .fire             (fire)
   );

   // Header built straight off the queue heads
   rstt_hdr_gen u_hdr_gen (
      .hdr_addr (aw_head_addr),
      .hdr_id   (aw_head_id),
      .hdr_strb (w_head_strb),
      .hdr_word (hdr_word),
      .pkt_size (pkt_size)
   );

   vc_pkt_reg u_pkt_reg (
      .aclk         (aclk),
      .aresetn      (aresetn),
      .fire         (fire),
      .hdr_word     (hdr_word),
      .pkt_size     (pkt_size),
      .line_data    (w_head_data),
      .vc_pkt_data  (vc_pkt_data),
      .vc_pkt_size  (vc_pkt_size),
      .vc_pkt_valid (vc_pkt_valid)
   );

endmodule

//--- tb/wr_req_checker.sv
`timescale 1ns/1ns

module wr_req_checker import eci_pkg::*; #(
   parameter int VC_CREDITS = 4
) (
   input  logic                                         aclk,
   input  logic                                         aresetn,
   input  logic [ECI_PKT_WORDS-1:0][ECI_WORD_WIDTH-1:0] vc_pkt_data,
   input  logic [ECI_PKT_SIZE_WIDTH-1:0]                vc_pkt_size,
   input  logic                                         vc_pkt_valid,
   input  logic                                         vc_credit_return,
   input  logic                                         exp_push,
   input  logic [ECI_PKT_WORDS-1:0][ECI_WORD_WIDTH-1:0] exp_data,
   input  logic [ECI_PKT_SIZE_WIDTH-1:0]                exp_size,
   output int                                           pkt_count,
   output int                                           err_count,
   output int                                           pending,
   output int                                           outstanding
);

   // Expected packets, oldest first
   logic [ECI_PKT_WORDS-1:0][ECI_WORD_WIDTH-1:0] data_q [$];
   logic [ECI_PKT_SIZE_WIDTH-1:0]                size_q [$];

   task automatic report_mismatch(input string msg);
      err_count++;
      $display("Fail %0t ns: %s", $time, msg);
   endtask

   // Compare one VC packet with the oldest expected entry
   task automatic check_packet();
      logic [ECI_PKT_WORDS-1:0][ECI_WORD_WIDTH-1:0] want;
      logic [ECI_PKT_SIZE_WIDTH-1:0]                want_size;
      if (data_q.size() == 0) begin
         err_count++;
         $display("A VC packet arrived at %0t ns with no request waiting for it", $time);
         return;
      end
      want      = data_q.pop_front();
      want_size = size_q.pop_front();
      pkt_count++;
      if (vc_pkt_size != want_size) begin
         report_mismatch($sformatf("packet %0d size %0d, expected %0d",
            pkt_count, vc_pkt_size, want_size));
      end
      // Words past the packet size carry no meaning
      for (int i = 0; i < ECI_PKT_WORDS; i++) begin
         if (i < int'(want_size) && vc_pkt_data[i] != want[i]) begin
            report_mismatch($sformatf("packet %0d word %0d is %h, expected %h",
               pkt_count, i, vc_pkt_data[i], want[i]));
         end
      end
   endtask

   always @(posedge aclk) begin
      if (!aresetn) begin
         if (vc_pkt_valid) begin
            report_mismatch("vc_pkt_valid high during reset");
         end
      end else begin
         // New pair first, its packet is two cycles away at the earliest
         if (exp_push) begin
            data_q.push_back(exp_data);
            size_q.push_back(exp_size);
         end
         if (vc_pkt_valid) begin
            check_packet();
         end
         // Packets sent but not yet paid back by the VC
         outstanding = outstanding + (vc_pkt_valid ? 1 : 0) - (vc_credit_return ? 1 : 0);
         if (outstanding > VC_CREDITS) begin
            report_mismatch($sformatf("%0d packets outstanding, credit limit %0d",
               outstanding, VC_CREDITS));
         end
         pending = data_q.size();
      end
   end

endmodule

//--- tb/tb_eci_wr_req.sv
`timescale 1ns/1ns

module tb_eci_wr_req import eci_pkg::*; ();

   localparam int FIFO_DEPTH = 4;
   localparam int VC_CREDITS = 4;
   localparam int WAIT_LIMIT = 2000;
   localparam int NUM_RANDOM = 64;

   logic                                         aclk = 1'b0;
   logic                                         aresetn = 1'b0;
   logic [ECI_ID_WIDTH-1:0]                      s_axi_awid = '0;
   logic [ECI_ADDR_WIDTH-1:0]                    s_axi_awaddr = '0;
   logic                                         s_axi_awvalid = 1'b0;
   logic                                         s_axi_awready;
   logic [ECI_CL_WIDTH-1:0]                      s_axi_wdata = '0;
   logic [ECI_STRB_WIDTH-1:0]                    s_axi_wstrb = '0;
   logic                                         s_axi_wlast = 1'b0;
   logic                                         s_axi_wvalid = 1'b0;
   logic                                         s_axi_wready;
   logic [ECI_PKT_WORDS-1:0][ECI_WORD_WIDTH-1:0] vc_pkt_data;
   logic [ECI_PKT_SIZE_WIDTH-1:0]                vc_pkt_size;
   logic                                         vc_pkt_valid;
   logic                                         vc_credit_return = 1'b0;

   // Expected packet handed to the checker
   logic                                         exp_push = 1'b0;
   logic [ECI_PKT_WORDS-1:0][ECI_WORD_WIDTH-1:0] exp_data = '0;
   logic [ECI_PKT_SIZE_WIDTH-1:0]                exp_size = '0;
   int pkt_count;
   int err_count;
   int pending;
   int outstanding;

   // Accepted beats waiting for their partner
   logic [ECI_ID_WIDTH-1:0]   aw_id_q [$];
   logic [ECI_ADDR_WIDTH-1:0] aw_addr_q [$];
   logic [ECI_CL_WIDTH-1:0]   w_data_q [$];
   logic [ECI_STRB_WIDTH-1:0] w_strb_q [$];

   // Separate LFSR streams for stimulus and credit delays
   logic [31:0] stim_lfsr = 32'd87460;
   logic [31:0] crd_lfsr = 32'd87460;
   logic        credit_pause = 1'b0;
   int          ret_due [$];
   int          cyc = 0;
   int          pairs_sent = 0;
   int          tb_errs = 0;
   int          tests_ok = 0;
   int          tests_bad = 0;

   logic [ECI_ID_WIDTH-1:0]   r_id [NUM_RANDOM];
   logic [ECI_ADDR_WIDTH-1:0] r_addr [NUM_RANDOM];
   logic [ECI_CL_WIDTH-1:0]   r_data [NUM_RANDOM];
   logic [ECI_STRB_WIDTH-1:0] r_strb [NUM_RANDOM];
   logic [1:0]                aw_gap [NUM_RANDOM];
   logic [1:0]                w_gap [NUM_RANDOM];

   always #5 aclk = ~aclk;

   eci_wr_req_top #(.FIFO_DEPTH(FIFO_DEPTH), .VC_CREDITS(VC_CREDITS)) dut (.*);

   wr_req_checker #(.VC_CREDITS(VC_CREDITS)) pkt_check (.*);

   // Galois form, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // One LFSR step per bit taken
   task automatic draw_bits(inout logic [31:0] st, input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v[i] = st[0];
         st = lfsr_next(st);
      end
   endtask

   // Expected VC packet for one AW/W pair
   function automatic void ref_packet(
      input  logic [ECI_ID_WIDTH-1:0]                   id,
      input  logic [ECI_ADDR_WIDTH-1:0]                 addr,
      input  logic [ECI_CL_WIDTH-1:0]                   data,
      input  logic [ECI_STRB_WIDTH-1:0]                 strb,
      output logic [ECI_PKT_WORDS-1:0][ECI_WORD_WIDTH-1:0] pkt,
      output logic [ECI_PKT_SIZE_WIDTH-1:0]             size
   );
      logic [3:0]  mask;
      logic [32:0] cl_idx;
      int          top;
      top = 0;
      for (int k = 0; k < 4; k++) begin
         mask[k] = |strb[32*k +: 32];
         if (mask[k]) begin
            top = k;
         end
      end
      // Low five index bits folded with index bits 9:5
      cl_idx = addr[39:7];
      cl_idx[4:0] = cl_idx[4:0] ^ cl_idx[9:5];
      pkt[0] = {ECI_CMD_MREQ_RSTT, id, mask, 1'b1, 8'h00, cl_idx, 7'h00};
      pkt[16:1] = data;
      size = 5'(1 + 4 * (top + 1));
   endfunction

   // Pair accepted beats in arrival order
   always @(posedge aclk) begin : pair_monitor
      logic [ECI_PKT_WORDS-1:0][ECI_WORD_WIDTH-1:0] pkt;
      logic [ECI_PKT_SIZE_WIDTH-1:0]                size;
      exp_push <= 1'b0;
      if (aresetn) begin
         if (s_axi_awvalid && s_axi_awready) begin
            aw_id_q.push_back(s_axi_awid);
            aw_addr_q.push_back(s_axi_awaddr);
         end
         if (s_axi_wvalid && s_axi_wready) begin
            w_data_q.push_back(s_axi_wdata);
            w_strb_q.push_back(s_axi_wstrb);
         end
         if (aw_id_q.size() > 0 && w_data_q.size() > 0) begin
            ref_packet(aw_id_q.pop_front(), aw_addr_q.pop_front(), w_data_q.pop_front(),
               w_strb_q.pop_front(), pkt, size);
            exp_push <= 1'b1;
            exp_data <= pkt;
            exp_size <= size;
            pairs_sent++;
         end
      end
   end

   // VC side pays a credit back 0 to 7 cycles after each packet
   always @(posedge aclk) begin : credit_sched
      logic [63:0] d;
      cyc++;
      if (aresetn && vc_pkt_valid) begin
         draw_bits(crd_lfsr, 3, d);
         ret_due.push_back(cyc + int'(d[2:0]));
      end
   end

   always @(negedge aclk) begin
      if (!credit_pause && ret_due.size() > 0 && ret_due[0] <= cyc) begin
         vc_credit_return = 1'b1;
         void'(ret_due.pop_front());
      end else begin
         vc_credit_return = 1'b0;
      end
   end

   task automatic check_timeout(input int t, input string what);
      if (t >= WAIT_LIMIT) begin
         tb_errs++;
         $display("Timeout: %s", what);
      end
   endtask

   task automatic make_pair(output logic [5:0] id, output logic [39:0] addr,
                            output logic [1023:0] data, output logic [127:0] strb);
      logic [63:0] v;
      draw_bits(stim_lfsr, 6, v);
      id = v[5:0];
      draw_bits(stim_lfsr, 40, v);
      addr = v[39:0];
      for (int i = 0; i < 18; i++) begin
         draw_bits(stim_lfsr, 64, v);
         if (i < 16) data[64*i +: 64] = v;
         else strb[64*(i-16) +: 64] = v;
      end
   endtask

   // Hold valid until the handshake edge has passed
   task automatic send_aw(input logic [5:0] id, input logic [39:0] addr);
      int t;
      t = 0;
      s_axi_awid    = id;
      s_axi_awaddr  = addr;
      s_axi_awvalid = 1'b1;
      while (!s_axi_awready && t < WAIT_LIMIT) begin
         @(negedge aclk);
         t++;
      end
      check_timeout(t, "AW beat was never accepted");
      @(negedge aclk);
      s_axi_awvalid = 1'b0;
   endtask

   task automatic send_w(input logic [1023:0] data, input logic [127:0] strb);
      int t;
      t = 0;
      s_axi_wdata  = data;
      s_axi_wstrb  = strb;
      s_axi_wlast  = 1'b1;
      s_axi_wvalid = 1'b1;
      while (!s_axi_wready && t < WAIT_LIMIT) begin
         @(negedge aclk);
         t++;
      end
      check_timeout(t, "W beat was never accepted");
      @(negedge aclk);
      s_axi_wvalid = 1'b0;
   endtask

   task automatic send_pair(input logic [5:0] id, input logic [39:0] addr,
                            input logic [1023:0] data, input logic [127:0] strb);
      fork
         send_aw(id, addr);
         send_w(data, strb);
      join
   endtask

   task automatic send_aw_stream();
      for (int i = 0; i < NUM_RANDOM; i++) begin
         repeat (aw_gap[i]) @(negedge aclk);
         send_aw(r_id[i], r_addr[i]);
      end
   endtask

   task automatic send_w_stream();
      for (int i = 0; i < NUM_RANDOM; i++) begin
         repeat (w_gap[i]) @(negedge aclk);
         send_w(r_data[i], r_strb[i]);
      end
   endtask

   // Every paired request has come out and been checked
   task automatic wait_drain();
      int t;
      t = 0;
      while ((pkt_count != pairs_sent || pending != 0) && t < WAIT_LIMIT) begin
         @(negedge aclk);
         t++;
      end
      check_timeout(t, "queued requests did not all leave as VC packets");
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (tb_errs + err_count == errs_before) begin
         tests_ok++;
         $display("Test %s: pass", name);
      end else begin
         tests_bad++;
         $display("Test %s: fail", name);
      end
   endtask

   initial begin
      logic [5:0]    id;
      logic [39:0]   addr;
      logic [1023:0] data;
      logic [127:0]  strb;
      logic [63:0]   v;
      int            errs;
      int            base;
      int            t;

      // Reset and idle readiness
      repeat (10) @(negedge aclk);
      aresetn = 1'b1;
      t = 0;
      while (!(s_axi_awready && s_axi_wready) && t < WAIT_LIMIT) begin
         @(negedge aclk);
         t++;
      end
      check_timeout(t, "AXI readies did not rise after reset");
      finish_test("1 reset state", 0);

      // Single full cache line
      errs = tb_errs + err_count;
      make_pair(id, addr, data, strb);
      send_pair(id, addr, data, '1);
      wait_drain();
      finish_test("2 full-line write", errs);

      // Highest active sub-cache-line 0, 1, 2, then an empty strobe
      errs = tb_errs + err_count;
      for (int k = 0; k < 4; k++) begin
         make_pair(id, addr, data, strb);
         draw_bits(stim_lfsr, 5, v);
         for (int b = 32 * (k + 1); b < 128; b++) begin
            strb[b] = 1'b0;
         end
         if (k < 3) strb[32*k + int'(v[4:0])] = 1'b1;
         else strb = '0;
         send_pair(id, addr, data, strb);
      end
      wait_drain();
      finish_test("3 strobe to size", errs);

      // Random pairs, AW and W timing independent
      errs = tb_errs + err_count;
      for (int i = 0; i < NUM_RANDOM; i++) begin
         make_pair(r_id[i], r_addr[i], r_data[i], r_strb[i]);
         draw_bits(stim_lfsr, 6, v);
         aw_gap[i] = v[1:0];
         w_gap[i]  = v[3:2];
         // Trim the strobe so sizes vary
         for (int b = 32 * (int'(v[5:4]) + 1); b < 128; b++) begin
            r_strb[i][b] = 1'b0;
         end
      end
      fork
         send_aw_stream();
         send_w_stream();
      join
      wait_drain();
      finish_test("4 aliasing and order", errs);

      // Credit stall fills both FIFOs
      errs = tb_errs + err_count;
      t = 0;
      while (outstanding != 0 && t < WAIT_LIMIT) begin
         @(negedge aclk);
         t++;
      end
      check_timeout(t, "credits did not all come back");
      @(posedge aclk);
      credit_pause = 1'b1;
      @(negedge aclk);
      base = pkt_count;
      for (int i = 0; i < VC_CREDITS + FIFO_DEPTH; i++) begin
         make_pair(id, addr, data, strb);
         send_pair(id, addr, data, strb);
      end
      t = 0;
      while ((s_axi_awready || s_axi_wready || pkt_count - base < VC_CREDITS)
             && t < WAIT_LIMIT) begin
         @(negedge aclk);
         t++;
      end
      check_timeout(t, "AXI readies stayed high with credits paused");
      // Window where no further packet may appear
      repeat (10) @(negedge aclk);
      if (pkt_count - base != VC_CREDITS) begin
         tb_errs++;
         $display("Fail %0t ns: %0d packets with credits paused, expected %0d",
            $time, pkt_count - base, VC_CREDITS);
      end
      @(posedge aclk);
      credit_pause = 1'b0;
      wait_drain();
      finish_test("5 credit back-pressure", errs);

      $display("Summary: %0d tests passed, %0d failed, %0d packets checked, %0d errors",
         tests_ok, tests_bad, pkt_count, tb_errs + err_count);
      if (tests_bad == 0 && tb_errs + err_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- project.f
common/eci_pkg.sv
design/sync_fifo.sv
wr_req/wr_req_ctrl.sv
wr_req/rstt_hdr_gen.sv
wr_req/vc_pkt_reg.sv
design/eci_wr_req_top.sv
tb/wr_req_checker.sv
tb/tb_eci_wr_req.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
rm -f sim.log &&
verilator --binary --assert --top-module tb_eci_wr_req -f project.f &&
./obj_dir/Vtb_eci_wr_req > sim.log 2>&1 &&
cat sim.log &&
grep -q -F '*** PASSED ***' sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }
